// File: dv/fpu_cmp_tests.txt
# name req op opa opb clr | flag inv inf inv_sticky inf_sticky, all but name in hex
# op is {unordered, code}; sticky columns hold the status after the line
eq_one       1 0 3f800000 3f800000 0 1 0 0 0 0
gt_neg       1 2 bf800000 c0000000 0 1 0 0 0 0
le_false     1 5 40400000 40000000 0 0 0 0 0 0
eq_zeros     1 0 00000000 80000000 0 1 0 0 0 0
gt_denorm    1 2 00400000 00000001 0 1 0 0 0 0
lt_den_norm  1 4 00400000 00800000 0 1 0 0 0 0
lt_negden    1 4 80400000 80000001 0 1 0 0 0 0
le_zero_den  1 5 80000000 00000001 0 1 0 0 0 0
gt_inf_fin   1 2 7f800000 40000000 0 1 0 1 0 1
lt_ninf_fin  1 4 ff800000 c0400000 0 1 0 1 0 1
eq_inf_inf   1 0 7f800000 7f800000 0 1 0 1 0 1
gt_inf_ninf  1 2 7f800000 ff800000 0 1 0 1 0 1
clr_only     0 0 00000000 00000000 1 0 0 0 0 0
eq_qnan      1 0 7fc00000 3f800000 0 0 0 0 0 0
lt_qnan      1 4 7fc00000 3f800000 0 0 1 0 1 0
ueq_qnan     1 8 7fc00000 3f800000 0 1 0 0 1 0
ult_qnan     1 c 3f800000 7fc00000 0 1 0 0 1 0
eq_snan      1 0 7fa00000 3f800000 0 0 1 0 1 0
ueq_snan     1 8 7fa00000 3f800000 0 1 1 0 1 0
ule_snan_inf 1 d 7f800000 7fa00000 0 1 1 1 1 1
clr_req      1 2 40000000 3f800000 1 1 0 0 0 0
gt_inf_acc   1 2 7f800000 3f800000 0 1 0 1 0 1
lt_qnan_acc  1 4 7fc00000 00000000 0 0 1 0 1 1
clr_req_inf  1 3 ff800000 ff800000 1 1 0 1 0 1
ill6         1 6 3f800000 3f800000 0 0 0 0 0 1
ill7_qnan    1 7 7fc00000 3f800000 0 0 1 0 1 1
uill6_qnan   1 e 7fc00000 3f800000 0 0 0 0 1 1
clr_end      0 0 00000000 00000000 1 0 0 0 0 0

// File: dv/tb_fpu_cmp.sv
////////////////////////////////////////////////////////////////////////////
// fpu compare unit testbench
// replays each line of the tests file as one request to the compare unit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_fpu_cmp;

  localparam int RST_CYC = 4;
  localparam int MARGIN  = 20;

  // one line of the tests file
  typedef struct packed {
    logic [127:0] name;
    logic         req;
    logic [3:0]   op;
    logic [31:0]  opa;
    logic [31:0]  opb;
    logic         clr;
    logic         flag;
    logic         inv;
    logic         inf;
    logic         inv_st;
    logic         inf_st;
  } vec_t;

  logic                      clk = 1'b0;
  logic                      arst_n;
  logic                      req;
  logic                      clr;
  fpu_cmp_pkg::fpu_cmp_op_t  op;
  logic [31:0]               opa;
  logic [31:0]               opb;
  logic                      valid;
  fpu_cmp_pkg::fpu_cmp_res_t res;
  logic                      inv_sticky;
  logic                      inf_sticky;

  vec_t vecs[$];
  // negedge count at which each issued line gets checked
  int   due_q[$];
  int   idx_q[$];
  int   neg_cnt   = 0;
  int   cyc_limit = RST_CYC + MARGIN;
  int   seed      = 32'hd514_810c;

  fpu_cmp_top u_fpu_cmp_top (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .req_i        (req),
    .clr_i        (clr),
    .op_i         (op),
    .opa_i        (opa),
    .opb_i        (opb),
    .valid_o      (valid),
    .res_o        (res),
    .inv_sticky_o (inv_sticky),
    .inf_sticky_o (inf_sticky)
  );

  // 4 ns clock
  initial begin
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input string field,
                             input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      $display("ERROR %0s %0s expected %0b actual %0b", name, field, exp_v, act_v);
      abort_run();
    end
  endtask

  // lines starting with # are column notes
  task automatic load_tests();
    int           fd;
    int           n;
    string        line;
    logic [127:0] name_f;
    logic         req_f;
    logic [3:0]   op_f;
    logic [31:0]  opa_f;
    logic [31:0]  opb_f;
    logic         clr_f;
    logic         flag_f;
    logic         inv_f;
    logic         inf_f;
    logic         inv_st_f;
    logic         inf_st_f;
    vec_t         v;
    fd = $fopen("dv/fpu_cmp_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open the tests file dv/fpu_cmp_tests.txt");
      abort_run();
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", name_f, req_f, op_f,
                      opa_f, opb_f, clr_f, flag_f, inv_f, inf_f, inv_st_f, inf_st_f);
          if (n != 11) begin
            $display("malformed line in the tests file: %0s", line);
            abort_run();
          end else begin
            v.name   = name_f;
            v.req    = req_f;
            v.op     = op_f;
            v.opa    = opa_f;
            v.opb    = opb_f;
            v.clr    = clr_f;
            v.flag   = flag_f;
            v.inv    = inv_f;
            v.inf    = inf_f;
            v.inv_st = inv_st_f;
            v.inf_st = inf_st_f;
            vecs.push_back(v);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // response side sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : check_blk
    vec_t  v;
    string nm;
    neg_cnt = neg_cnt + 1;
    if (neg_cnt > cyc_limit) begin
      $display("timeout: the run did not end within %0d cycles", cyc_limit);
      abort_run();
    end else if (due_q.size() > 0 && due_q[0] == neg_cnt) begin
      v  = vecs[idx_q[0]];
      nm = $sformatf("%0s", v.name);
      // a clr-only line must not raise valid
      check_value(nm, "valid", v.req, valid);
      if (v.req) begin
        check_value(nm, "flag", v.flag, res.flag);
        check_value(nm, "inv", v.inv, res.inv);
        check_value(nm, "inf", v.inf, res.inf);
      end
      check_value(nm, "inv_sticky", v.inv_st, inv_sticky);
      check_value(nm, "inf_sticky", v.inf_st, inf_sticky);
      void'(due_q.pop_front());
      void'(idx_q.pop_front());
    end else begin
      check_value("idle", "valid", 1'b0, valid);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : drive_blk
    logic [31:0] rnd;
    int          gap;
    arst_n = 1'b0;
    req    = 1'b0;
    clr    = 1'b0;
    op     = '0;
    opa    = '0;
    opb    = '0;
    load_tests();
    // at most four cycles per line with the longest gap
    cyc_limit = 4 * vecs.size() + RST_CYC + MARGIN;
    repeat (RST_CYC) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < vecs.size(); i++) begin
      // about half the lines go back to back
      rnd = $random(seed);
      gap = rnd[2] ? 0 : int'(rnd[1:0]);
      repeat (gap) begin
        @(posedge clk);
        req <= 1'b0;
        clr <= 1'b0;
      end
      @(posedge clk);
      req <= vecs[i].req;
      clr <= vecs[i].clr;
      op  <= vecs[i].op;
      opa <= vecs[i].opa;
      opb <= vecs[i].opb;
      // DUT samples on the next edge and the negedge after it checks
      due_q.push_back(neg_cnt + 2);
      idx_q.push_back(i);
    end
    @(posedge clk);
    req <= 1'b0;
    clr <= 1'b0;
    while (due_q.size() > 0) @(posedge clk);
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: hw/fpu_cmp_latch.sv
////////////////////////////////////////////////////////////////////////////
// fpu compare result stage
// registers the compare result on each request and keeps sticky
// invalid and infinity status bits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fpu_cmp_latch (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      req_i,
  input  logic                      clr_i,
  input  fpu_cmp_pkg::fpu_cmp_res_t res_i,
  output logic                      valid_o,
  output fpu_cmp_pkg::fpu_cmp_res_t res_o,
  output logic                      inv_sticky_o,
  output logic                      inf_sticky_o
);

  // sticky base, a clear in the same cycle wipes the old status
  logic inv_keep;
  logic inf_keep;

  assign inv_keep = inv_sticky_o & ~clr_i;
  assign inf_keep = inf_sticky_o & ~clr_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o      <= 1'b0;
      res_o        <= '0;
      inv_sticky_o <= 1'b0;
      inf_sticky_o <= 1'b0;
    end else begin
      // one strobe per request
      valid_o <= req_i;
      if (req_i) begin
        res_o        <= res_i;
        // clear first, then or in the new bits
        inv_sticky_o <= inv_keep | res_i.inv;
        inf_sticky_o <= inf_keep | res_i.inf;
      end else if (clr_i) begin
        inv_sticky_o <= 1'b0;
        inf_sticky_o <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // result strobe trails the request by exactly one cycle
  a_valid_follows_req : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    valid_o == $past(req_i)
  );

  // status only drops after a clear
  a_sticky_hold : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ($fell(inv_sticky_o) || $fell(inf_sticky_o)) |-> $past(clr_i)
  );

endmodule

// File: hw/fpu_cmp_pkg.sv
////////////////////////////////////////////////////////////////////////////
// fpu compare package
// opcode, unpacked operand and result types for the single-precision
// compare unit, plus the float field widths
////////////////////////////////////////////////////////////////////////////

package fpu_cmp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // float format
  ////////////////////////////////////////////////////////////////////////////

  // raw ieee-754 single fields
  localparam int EXP_FIELD_W   = 8;
  localparam int FRACT_FIELD_W = 23;

  // widened exponent, as the or1k fpu carries it internally
  localparam int EXP_W   = 10;
  // fraction with hidden bit in front
  localparam int FRACT_W = 24;

  ////////////////////////////////////////////////////////////////////////////
  // generic compare codes
  ////////////////////////////////////////////////////////////////////////////

  // low bits of the or1k lf.sf* opcodes
  localparam logic [2:0] CMP_EQ = 3'd0;
  localparam logic [2:0] CMP_NE = 3'd1;
  localparam logic [2:0] CMP_GT = 3'd2;
  localparam logic [2:0] CMP_GE = 3'd3;
  localparam logic [2:0] CMP_LT = 3'd4;
  localparam logic [2:0] CMP_LE = 3'd5;
  // 6 and 7 are illegal, flag stays clear

  // compare opcode
  typedef struct packed {
    // nan operand makes the flag true
    logic       unordered;
    logic [2:0] generic;
  } fpu_cmp_op_t;

  ////////////////////////////////////////////////////////////////////////////
  // operand and result
  ////////////////////////////////////////////////////////////////////////////

  // one operand after classification
  typedef struct packed {
    logic               sign;
    logic [EXP_W-1:0]   exp10;
    logic [FRACT_W-1:0] fract24;
    logic               snan;
    logic               qnan;
    logic               inf;
    logic               zero;
  } fpu_operand_t;

  // compare outcome plus exceptions
  typedef struct packed {
    logic flag;
    // invalid operation
    logic inv;
    // an operand was infinite
    logic inf;
  } fpu_cmp_res_t;

endpackage

// File: hw/fpu_cmp_top.sv
////////////////////////////////////////////////////////////////////////////
// fpu compare unit
// two operand classifiers, the compare core and the result stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fpu_cmp_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      req_i,
  input  logic                      clr_i,
  input  fpu_cmp_pkg::fpu_cmp_op_t  op_i,
  input  logic [31:0]               opa_i,
  input  logic [31:0]               opb_i,
  output logic                      valid_o,
  output fpu_cmp_pkg::fpu_cmp_res_t res_o,
  output logic                      inv_sticky_o,
  output logic                      inf_sticky_o
);

  // classified operands
  fpu_cmp_pkg::fpu_operand_t opnd_a;
  fpu_cmp_pkg::fpu_operand_t opnd_b;

  // unregistered compare result
  fpu_cmp_pkg::fpu_cmp_res_t cmp_res;

  fpu_unpack u_unpack_a (
    .opnd_i (opa_i),
    .opnd_o (opnd_a)
  );

  fpu_unpack u_unpack_b (
    .opnd_i (opb_i),
    .opnd_o (opnd_b)
  );

  // same cycle as the request
  fpu_fcmp u_fcmp (
    .op_i  (op_i),
    .opa_i (opnd_a),
    .opb_i (opnd_b),
    .res_o (cmp_res)
  );

  // one cycle later
  fpu_cmp_latch u_latch (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_i        (req_i),
    .clr_i        (clr_i),
    .res_i        (cmp_res),
    .valid_o      (valid_o),
    .res_o        (res_o),
    .inv_sticky_o (inv_sticky_o),
    .inf_sticky_o (inf_sticky_o)
  );

endmodule

// File: hw/fpu_fcmp.sv
////////////////////////////////////////////////////////////////////////////
// fpu compare core
// combinational ordered/unordered compare of two classified operands,
// with invalid and infinity detection
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fpu_fcmp (
  input  fpu_cmp_pkg::fpu_cmp_op_t  op_i,
  input  fpu_cmp_pkg::fpu_operand_t opa_i,
  input  fpu_cmp_pkg::fpu_operand_t opb_i,
  output fpu_cmp_pkg::fpu_cmp_res_t res_o
);

  ////////////////////////////////////////////////////////////////////////////
  // exception analysis
  ////////////////////////////////////////////////////////////////////////////

  logic qnan;
  logic snan;
  logic anan;
  logic eqne;
  logic legal;

  assign qnan = opa_i.qnan | opb_i.qnan;
  assign snan = opa_i.snan | opb_i.snan;
  assign anan = qnan | snan;

  // eq/ne never trap on quiet nan
  assign eqne  = (op_i.generic == fpu_cmp_pkg::CMP_EQ) |
                 (op_i.generic == fpu_cmp_pkg::CMP_NE);
  assign legal = (op_i.generic <= fpu_cmp_pkg::CMP_LE);

  ////////////////////////////////////////////////////////////////////////////
  // magnitude compare
  ////////////////////////////////////////////////////////////////////////////

  logic exp_gt;
  logic exp_eq;
  logic fract_gt;
  logic fract_eq;
  logic mag_gt;
  logic mag_eq;
  logic all_zero;

  assign exp_gt   = opa_i.exp10 > opb_i.exp10;
  assign exp_eq   = opa_i.exp10 == opb_i.exp10;
  assign fract_gt = opa_i.fract24 > opb_i.fract24;
  assign fract_eq = opa_i.fract24 == opb_i.fract24;

  // |a| vs |b|, denormals order right without normalising
  assign mag_gt = exp_gt | (exp_eq & fract_gt);
  assign mag_eq = exp_eq & fract_eq;

  // +0 and -0 are equal
  assign all_zero = opa_i.zero & opb_i.zero;

  ////////////////////////////////////////////////////////////////////////////
  // ordering
  ////////////////////////////////////////////////////////////////////////////

  // at most one set, none when unordered
  logic a_gt_b;
  logic a_lt_b;
  logic a_eq_b;

  always_comb begin
    a_gt_b = 1'b0;
    a_lt_b = 1'b0;
    a_eq_b = 1'b0;
    if (anan) begin
      // unordered, no relation holds
      a_eq_b = 1'b0;
    end else if (opa_i.inf & opb_i.inf) begin
      // both infinite, sign decides
      a_eq_b = (opa_i.sign == opb_i.sign);
      a_lt_b = opa_i.sign & ~opb_i.sign;
      a_gt_b = ~opa_i.sign & opb_i.sign;
    end else if (opa_i.inf) begin
      a_gt_b = ~opa_i.sign;
      a_lt_b = opa_i.sign;
    end else if (opb_i.inf) begin
      a_lt_b = ~opb_i.sign;
      a_gt_b = opb_i.sign;
    end else if (all_zero) begin
      a_eq_b = 1'b1;
    end else if (opa_i.sign != opb_i.sign) begin
      // negative side is smaller
      a_lt_b = opa_i.sign;
      a_gt_b = opb_i.sign;
    end else if (mag_eq) begin
      a_eq_b = 1'b1;
    end else begin
      // both negative flips the magnitude order
      a_gt_b = mag_gt ^ opa_i.sign;
      a_lt_b = ~mag_gt ^ opa_i.sign;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // flag and exceptions
  ////////////////////////////////////////////////////////////////////////////

  logic generic_flag;

  // map the order through the compare code
  always_comb begin
    case (op_i.generic)
      fpu_cmp_pkg::CMP_EQ: generic_flag = a_eq_b;
      fpu_cmp_pkg::CMP_NE: generic_flag = ~a_eq_b;
      fpu_cmp_pkg::CMP_GT: generic_flag = a_gt_b;
      fpu_cmp_pkg::CMP_GE: generic_flag = a_gt_b | a_eq_b;
      fpu_cmp_pkg::CMP_LT: generic_flag = a_lt_b;
      fpu_cmp_pkg::CMP_LE: generic_flag = a_lt_b | a_eq_b;
      default:             generic_flag = 1'b0;
    endcase
  end

  // unordered codes go true on any nan, illegal codes stay clear
  assign res_o.flag = (op_i.unordered & anan & legal) | generic_flag;

  // snan signals for every code,
  // a quiet nan only in ordered gt/ge/lt/le
  assign res_o.inv = snan | (~eqne & anan & ~op_i.unordered);

  assign res_o.inf = opa_i.inf | opb_i.inf;

endmodule

// File: hw/fpu_unpack.sv
////////////////////////////////////////////////////////////////////////////
// fpu operand classifier
// splits a raw single-precision word into sign, widened exponent,
// fraction with hidden bit and nan/inf/zero class flags
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fpu_unpack (
  input  logic [31:0]                opnd_i,
  output fpu_cmp_pkg::fpu_operand_t opnd_o
);

  // raw fields
  logic [fpu_cmp_pkg::EXP_FIELD_W-1:0]   exp_raw;
  logic [fpu_cmp_pkg::FRACT_FIELD_W-1:0] fract_raw;

  // field classes
  logic exp_ones;
  logic exp_zero;
  logic fract_zero;
  logic is_nan;

  assign exp_raw   = opnd_i[30:23];
  assign fract_raw = opnd_i[22:0];

  assign exp_ones   = &exp_raw;
  assign exp_zero   = ~|exp_raw;
  assign fract_zero = ~|fract_raw;
  assign is_nan     = exp_ones & ~fract_zero;

  assign opnd_o.sign  = opnd_i[31];
  // zero-extend, denormals keep exponent 0
  assign opnd_o.exp10 = {{(fpu_cmp_pkg::EXP_W - fpu_cmp_pkg::EXP_FIELD_W){1'b0}}, exp_raw};
  // hidden bit clear for zero and denormal
  assign opnd_o.fract24 = {~exp_zero, fract_raw};

  // quiet nan has the top fraction bit set
  assign opnd_o.qnan = is_nan & fract_raw[fpu_cmp_pkg::FRACT_FIELD_W-1];
  assign opnd_o.snan = is_nan & ~fract_raw[fpu_cmp_pkg::FRACT_FIELD_W-1];
  assign opnd_o.inf  = exp_ones & fract_zero;
  assign opnd_o.zero = exp_zero & fract_zero;

endmodule

// File: run.sh
#!/bin/sh
# build and run the compare unit testbench, the exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_fpu_cmp -Mdir obj_dir &&
./obj_dir/Vtb_fpu_cmp || exit 1

// File: tb.f
hw/fpu_cmp_pkg.sv
hw/fpu_unpack.sv
hw/fpu_fcmp.sv
hw/fpu_cmp_latch.sv
hw/fpu_cmp_top.sv
dv/tb_fpu_cmp.sv
